// File: logic/rv_pkg.sv
`default_nettype none

// Shared ISA widths, encodings and ALU op codes for the RV64I execute slice.
package rv_pkg;

  // Datapath and register file geometry.
  localparam int xlen       = 64; // Register width.
  localparam int reg_addr_w = 5;  // Register address width.
  localparam int reg_num    = 32; // Number of general registers.
  localparam int instr_w    = 32; // Instruction width.
  localparam int shamt_w    = 6;  // RV64 shift amount width.

  // Reset value, also returned by a disabled read port.
  localparam logic [xlen-1:0] reg_init = '0;

  // Major opcodes.
  localparam logic [6:0] opc_op     = 7'b0110011; // Register-register ALU.
  localparam logic [6:0] opc_op_imm = 7'b0010011; // Register-immediate ALU.
  localparam logic [6:0] opc_lui    = 7'b0110111; // Load upper immediate.

  // funct3 field values, shared by OP and OP-IMM.
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_sltu    = 3'b011;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_srl_sra = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;

  // funct7 field values.
  // Bit 30 picks SUB over ADD and SRA over SRL.
  localparam logic [6:0] f7_base = 7'b0000000;
  localparam logic [6:0] f7_alt  = 7'b0100000;

  // ALU operations.
  typedef enum logic [3:0] {
    alu_add  = 4'd0,
    alu_sub  = 4'd1,
    alu_sll  = 4'd2,
    alu_slt  = 4'd3,
    alu_sltu = 4'd4,
    alu_xor  = 4'd5,
    alu_srl  = 4'd6,
    alu_sra  = 4'd7,
    alu_or   = 4'd8,
    alu_and  = 4'd9
  } alu_op_e;

endpackage

`default_nettype wire

// File: logic/rv_decode.sv
`timescale 1ns/1ps
`default_nettype none

// Instruction decoder for the OP, OP-IMM and LUI groups.
// Purely combinational.
module rv_decode (
  input  logic                          instr_valid,
  input  logic [rv_pkg::instr_w-1:0]    instr,
  output logic [rv_pkg::reg_addr_w-1:0] rs1_addr,
  output logic [rv_pkg::reg_addr_w-1:0] rs2_addr,
  output logic [rv_pkg::reg_addr_w-1:0] rd_addr,
  output logic                          rs1_en,
  output logic                          rs2_en,
  output logic                          rd_we,
  output logic                          use_imm,
  output logic                          illegal_instr,
  output logic [rv_pkg::xlen-1:0]       imm,
  output rv_pkg::alu_op_e               alu_op
);

  logic [6:0]              opcode;
  logic [2:0]              funct3;
  logic [6:0]              funct7;
  logic [5:0]              funct6; // OP-IMM shifts use one bit more shamt.
  logic                    f7_is_base;
  logic                    f7_is_alt;
  logic                    f6_is_base;
  logic                    f6_is_alt;
  logic                    legal;
  logic [rv_pkg::xlen-1:0] imm_i;
  logic [rv_pkg::xlen-1:0] imm_u;

  // Fixed instruction fields.
  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign funct6 = instr[31:26];

  assign rd_addr  = instr[11:7];
  assign rs1_addr = instr[19:15];
  assign rs2_addr = instr[24:20];

  assign f7_is_base = (funct7 == rv_pkg::f7_base);
  assign f7_is_alt  = (funct7 == rv_pkg::f7_alt);
  assign f6_is_base = (funct6 == rv_pkg::f7_base[6:1]); // Bit 25 is shamt[5].
  assign f6_is_alt  = (funct6 == rv_pkg::f7_alt[6:1]);

  // I-type immediate, sign extended.
  assign imm_i = {{(rv_pkg::xlen-12){instr[31]}}, instr[31:20]};
  // U-type immediate, shifted up and sign extended from bit 31.
  assign imm_u = {{(rv_pkg::xlen-32){instr[31]}}, instr[31:12], 12'b0};

  always_comb begin
    legal   = 1'b0;
    rs1_en  = 1'b0;
    rs2_en  = 1'b0;
    use_imm = 1'b0;
    imm     = imm_i;
    alu_op  = rv_pkg::alu_add;

    case (opcode)
      rv_pkg::opc_op: begin
        rs1_en = 1'b1;
        rs2_en = 1'b1;
        case (funct3)
          rv_pkg::f3_add_sub: begin
            if (f7_is_base) begin
              alu_op = rv_pkg::alu_add;
              legal  = 1'b1;
            end else if (f7_is_alt) begin
              alu_op = rv_pkg::alu_sub; // SUB.
              legal  = 1'b1;
            end
          end
          rv_pkg::f3_srl_sra: begin
            if (f7_is_base) begin
              alu_op = rv_pkg::alu_srl;
              legal  = 1'b1;
            end else if (f7_is_alt) begin
              alu_op = rv_pkg::alu_sra; // SRA.
              legal  = 1'b1;
            end
          end
          rv_pkg::f3_sll: begin
            alu_op = rv_pkg::alu_sll;
            legal  = f7_is_base;
          end
          rv_pkg::f3_slt: begin
            alu_op = rv_pkg::alu_slt;
            legal  = f7_is_base;
          end
          rv_pkg::f3_sltu: begin
            alu_op = rv_pkg::alu_sltu;
            legal  = f7_is_base;
          end
          rv_pkg::f3_xor: begin
            alu_op = rv_pkg::alu_xor;
            legal  = f7_is_base;
          end
          rv_pkg::f3_or: begin
            alu_op = rv_pkg::alu_or;
            legal  = f7_is_base;
          end
          rv_pkg::f3_and: begin
            alu_op = rv_pkg::alu_and;
            legal  = f7_is_base;
          end
        endcase
      end

      rv_pkg::opc_op_imm: begin
        rs1_en  = 1'b1;
        use_imm = 1'b1;
        legal   = 1'b1; // Only shifts have further constraints.
        case (funct3)
          rv_pkg::f3_add_sub: alu_op = rv_pkg::alu_add;
          rv_pkg::f3_slt:     alu_op = rv_pkg::alu_slt;
          rv_pkg::f3_sltu:    alu_op = rv_pkg::alu_sltu;
          rv_pkg::f3_xor:     alu_op = rv_pkg::alu_xor;
          rv_pkg::f3_or:      alu_op = rv_pkg::alu_or;
          rv_pkg::f3_and:     alu_op = rv_pkg::alu_and;
          rv_pkg::f3_sll: begin
            alu_op = rv_pkg::alu_sll;
            legal  = f6_is_base; // SLLI has no alternate form.
          end
          rv_pkg::f3_srl_sra: begin
            alu_op = f6_is_alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
            legal  = f6_is_base | f6_is_alt;
          end
        endcase
      end

      rv_pkg::opc_lui: begin
        use_imm = 1'b1;   // rs1 stays disabled, so operand a is zero.
        imm     = imm_u;
        legal   = 1'b1;
      end

      default: ; // Everything else is illegal.
    endcase

    // No operand reads for a rejected encoding.
    if (!legal) begin
      rs1_en = 1'b0;
      rs2_en = 1'b0;
    end
  end

  assign rd_we         = instr_valid & legal;
  assign illegal_instr = instr_valid & ~legal;

endmodule

`default_nettype wire

// File: logic/rv_reg_file.sv
`timescale 1ns/1ps
`default_nettype none

// 32 x 64 general register file.
// Two enabled read ports, one write port and a debug read port.
module rv_reg_file (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          rs1_en,
  input  logic                          rs2_en,
  input  logic [rv_pkg::reg_addr_w-1:0] rs1_addr,
  input  logic [rv_pkg::reg_addr_w-1:0] rs2_addr,
  output logic [rv_pkg::xlen-1:0]       rs1_data,
  output logic [rv_pkg::xlen-1:0]       rs2_data,
  input  logic                          wr_en,
  input  logic [rv_pkg::reg_addr_w-1:0] wr_addr,
  input  logic [rv_pkg::xlen-1:0]       wr_data,
  input  logic [rv_pkg::reg_addr_w-1:0] dbg_addr,
  output logic [rv_pkg::xlen-1:0]       dbg_data
);

  logic [rv_pkg::xlen-1:0] regs [rv_pkg::reg_num];
  logic                    wr_act; // Write that actually lands.

  // x0 is never written, so it keeps reg_init.
  assign wr_act = wr_en && (wr_addr != '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < rv_pkg::reg_num; i++) begin
        regs[i] <= rv_pkg::reg_init;
      end
    end else if (wr_act) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // Combinational reads.
  // A disabled port returns the reset value.
  assign rs1_data = rs1_en ? regs[rs1_addr] : rv_pkg::reg_init;
  assign rs2_data = rs2_en ? regs[rs2_addr] : rv_pkg::reg_init;

  assign dbg_data = regs[dbg_addr]; // Always live.

endmodule

`default_nettype wire

// File: logic/rv_alu.sv
`timescale 1ns/1ps
`default_nettype none

// 64-bit integer ALU.
// Add, subtract, logic, compare and shift. Purely combinational.
module rv_alu (
  input  logic [rv_pkg::xlen-1:0] a,
  input  logic [rv_pkg::xlen-1:0] b,
  input  rv_pkg::alu_op_e         op,
  output logic [rv_pkg::xlen-1:0] y
);

  logic [rv_pkg::shamt_w-1:0] shamt;    // Low bits of b only.
  logic                       lt_signed;
  logic                       lt_unsigned;
  logic [rv_pkg::xlen-1:0]    sum;
  logic [rv_pkg::xlen-1:0]    diff;
  logic [rv_pkg::xlen-1:0]    sra_res;

  assign shamt = b[rv_pkg::shamt_w-1:0];

  assign sum  = a + b;
  assign diff = a - b;

  // Compares.
  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  // Arithmetic shift keeps the sign bit.
  assign sra_res = $unsigned($signed(a) >>> shamt);

  always_comb begin
    case (op)
      rv_pkg::alu_add: begin
        y = sum;
      end
      rv_pkg::alu_sub: begin
        y = diff;
      end
      rv_pkg::alu_sll: begin
        y = a << shamt;
      end
      rv_pkg::alu_slt: begin
        y = {{(rv_pkg::xlen-1){1'b0}}, lt_signed};   // 1 or 0.
      end
      rv_pkg::alu_sltu: begin
        y = {{(rv_pkg::xlen-1){1'b0}}, lt_unsigned}; // 1 or 0.
      end
      rv_pkg::alu_xor: begin
        y = a ^ b;
      end
      rv_pkg::alu_srl: begin
        y = a >> shamt; // Zero fill.
      end
      rv_pkg::alu_sra: begin
        y = sra_res;
      end
      rv_pkg::alu_or: begin
        y = a | b;
      end
      rv_pkg::alu_and: begin
        y = a & b;
      end
      default: begin
        y = sum; // Unused codes behave as add.
      end
    endcase
  end

endmodule

`default_nettype wire

// File: logic/rv_int_core.sv
`timescale 1ns/1ps
`default_nettype none

// Integer execute slice of a small RV64I core.
// One instruction per strobe, write-back and retire one cycle later.
module rv_int_core (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          instr_valid,
  input  logic [rv_pkg::instr_w-1:0]    instr,
  input  logic [rv_pkg::reg_addr_w-1:0] dbg_addr,
  output logic                          retire_valid,
  output logic                          illegal,
  output logic [rv_pkg::reg_addr_w-1:0] retire_rd,
  output logic [rv_pkg::xlen-1:0]       retire_data,
  output logic [rv_pkg::xlen-1:0]       dbg_data
);

  logic [rv_pkg::reg_addr_w-1:0] rs1_addr;
  logic [rv_pkg::reg_addr_w-1:0] rs2_addr;
  logic [rv_pkg::reg_addr_w-1:0] rd_addr;
  logic                          rs1_en;
  logic                          rs2_en;
  logic                          rd_we;      // Already valid and legal.
  logic                          use_imm;
  logic                          illegal_instr;
  logic [rv_pkg::xlen-1:0]       imm;
  rv_pkg::alu_op_e               alu_op;
  logic [rv_pkg::xlen-1:0]       rs1_data;
  logic [rv_pkg::xlen-1:0]       rs2_data;
  logic [rv_pkg::xlen-1:0]       alu_b;
  logic [rv_pkg::xlen-1:0]       alu_y;

  rv_decode decode_i (
    .instr_valid   (instr_valid),
    .instr         (instr),
    .rs1_addr      (rs1_addr),
    .rs2_addr      (rs2_addr),
    .rd_addr       (rd_addr),
    .rs1_en        (rs1_en),
    .rs2_en        (rs2_en),
    .rd_we         (rd_we),
    .use_imm       (use_imm),
    .illegal_instr (illegal_instr),
    .imm           (imm),
    .alu_op        (alu_op)
  );

  // Write-back goes straight from the ALU, same edge as retire.
  rv_reg_file reg_file_i (
    .clk      (clk),
    .rst      (rst),
    .rs1_en   (rs1_en),
    .rs2_en   (rs2_en),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wr_en    (rd_we),
    .wr_addr  (rd_addr),
    .wr_data  (alu_y),
    .dbg_addr (dbg_addr),
    .dbg_data (dbg_data)
  );

  assign alu_b = use_imm ? imm : rs2_data; // Operand b select.

  rv_alu alu_i (
    .a  (rs1_data),
    .b  (alu_b),
    .op (alu_op),
    .y  (alu_y)
  );

  // Retirement and illegal pulse, one cycle after the strobe.
  always_ff @(posedge clk) begin
    if (rst) begin
      retire_valid <= 1'b0;
      illegal      <= 1'b0;
      retire_rd    <= '0;
      retire_data  <= '0;
    end else begin
      retire_valid <= rd_we;
      illegal      <= illegal_instr;
      if (rd_we) begin
        retire_rd   <= rd_addr;
        retire_data <= alu_y; // Includes writes to x0.
      end
    end
  end

endmodule

`default_nettype wire

// File: test/rv_int_core_assert.sv
`timescale 1ns/1ps
`default_nettype none

// Protocol checks on the core's outputs.
module rv_int_core_assert (
  input logic                          clk,
  input logic                          rst,
  input logic                          retire_valid,
  input logic                          illegal,
  input logic [rv_pkg::reg_addr_w-1:0] dbg_addr,
  input logic [rv_pkg::xlen-1:0]       dbg_data
);

  // An instruction either retires or is rejected, never both.
  retire_or_illegal: assert property (
    @(posedge clk) disable iff (rst) !(retire_valid && illegal)
  ) else $error("retire_valid and illegal high in the same cycle");

  // Both strobes are quiet right after a reset edge.
  quiet_after_reset: assert property (
    @(posedge clk) rst |=> (!retire_valid && !illegal)
  ) else $error("retire_valid or illegal high after reset");

  // x0 is hardwired.
  x0_reads_zero: assert property (
    @(posedge clk) disable iff (rst)
      (dbg_addr == '0) |-> (dbg_data == rv_pkg::reg_init)
  ) else $error("x0 read through the debug port is not zero");

endmodule

bind rv_int_core rv_int_core_assert assert_i (
  .clk          (clk),
  .rst          (rst),
  .retire_valid (retire_valid),
  .illegal      (illegal),
  .dbg_addr     (dbg_addr),
  .dbg_data     (dbg_data)
);

`default_nettype wire

// File: test/rv_int_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

// Testbench for rv_int_core.
// Random instruction stream checked against a register model.
module rv_int_core_tb;

  localparam int          period   = 100;                // ns.
  localparam int          n_instr  = 400;                // Random stream length.
  localparam int          n_cycles = n_instr + 2 * rv_pkg::reg_num + 100;
  localparam logic [31:0] seed     = 32'hf41e_8acc;

  logic                          clk;
  logic                          rst;
  logic                          instr_valid;
  logic [rv_pkg::instr_w-1:0]    instr;
  logic [rv_pkg::reg_addr_w-1:0] dbg_addr;
  logic                          retire_valid;
  logic                          illegal;
  logic [rv_pkg::reg_addr_w-1:0] retire_rd;
  logic [rv_pkg::xlen-1:0]       retire_data;
  logic [rv_pkg::xlen-1:0]       dbg_data;

  logic [rv_pkg::xlen-1:0]       model_regs [rv_pkg::reg_num]; // Reference registers.
  logic                          exp_retire;  // Expected for the next check.
  logic                          exp_illegal;
  logic [rv_pkg::reg_addr_w-1:0] exp_rd;
  logic [rv_pkg::xlen-1:0]       exp_data;
  logic [rv_pkg::reg_addr_w-1:0] last_rd;     // Source bias for dependencies.

  rv_int_core dut_i (
    .clk          (clk),
    .rst          (rst),
    .instr_valid  (instr_valid),
    .instr        (instr),
    .dbg_addr     (dbg_addr),
    .retire_valid (retire_valid),
    .illegal      (illegal),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data),
    .dbg_data     (dbg_data)
  );

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  // Watchdog sized from the stream and both sweeps.
  initial begin
    #(n_cycles * period);
    fail_run("timeout: the run did not reach its end in time");
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic check(input string name, input logic [63:0] actual,
                       input logic [63:0] expected);
    if (actual !== expected) begin
      fail_run($sformatf("error: %s actual %h expected %h", name, actual, expected));
    end
  endtask

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
      input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, rv_pkg::opc_op};
  endfunction

  function automatic logic [31:0] enc_i(input logic [2:0] f3, input logic [4:0] rd,
      input logic [4:0] rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, rv_pkg::opc_op_imm};
  endfunction

  // ISA reference. Returns legality and the result through res.
  function automatic logic predict(input logic [31:0] word, output logic [63:0] res);
    logic [6:0]  opcode;
    logic [2:0]  f3;
    logic [63:0] a;
    logic [63:0] b;
    logic [5:0]  sh;
    logic        is_imm;
    logic        base;
    logic        alt;
    logic        legal;
    opcode = word[6:0];
    f3     = word[14:12];
    is_imm = (opcode == rv_pkg::opc_op_imm);
    a      = model_regs[word[19:15]];
    b      = is_imm ? {{52{word[31]}}, word[31:20]} : model_regs[word[24:20]];
    sh     = b[5:0]; // RV64 takes six bits.
    if (is_imm) begin
      base = (word[31:26] == 6'b000000);
      alt  = (word[31:26] == 6'b010000);
    end else begin
      base = (word[31:25] == rv_pkg::f7_base);
      alt  = (word[31:25] == rv_pkg::f7_alt);
    end
    legal = 1'b0;
    res   = '0;
    if (opcode == rv_pkg::opc_lui) begin
      legal = 1'b1;
      res   = {{32{word[31]}}, word[31:12], 12'h000};
    end else if (is_imm || opcode == rv_pkg::opc_op) begin
      legal = is_imm || base; // Plain ops.
      case (f3)
        rv_pkg::f3_add_sub: begin
          legal = is_imm || base || alt;
          res   = (!is_imm && alt) ? a - b : a + b;
        end
        rv_pkg::f3_sll: begin
          legal = base;
          res   = a << sh;
        end
        rv_pkg::f3_slt: res = {63'b0, (a[63] != b[63]) ? a[63] : (a < b)};
        rv_pkg::f3_sltu: res = {63'b0, a < b};
        rv_pkg::f3_xor: res = a ^ b;
        rv_pkg::f3_or: res = a | b;
        rv_pkg::f3_and: res = a & b;
        default: begin // SRL and SRA.
          legal = base || alt;
          res   = (a >> sh) | ((alt && a[63]) ? ~({64{1'b1}} >> sh) : 64'h0);
        end
      endcase
    end
    return legal;
  endfunction

  function automatic logic [31:0] random_instr();
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [11:0] imm;
    logic [31:0] word;
    int          kind;
    kind = int'($urandom % 100);
    rd   = (($urandom % 8) == 0) ? 5'd0 : 5'($urandom); // x0 now and then.
    rs1  = (($urandom % 3) == 0) ? last_rd : 5'($urandom);
    rs2  = (($urandom % 4) == 0) ? last_rd : 5'($urandom);
    f3   = 3'($urandom);
    imm  = 12'($urandom);
    if (kind < 35) begin
      if ((f3 == rv_pkg::f3_add_sub || f3 == rv_pkg::f3_srl_sra) && ($urandom % 2 == 1)) begin
        word = enc_r(rv_pkg::f7_alt, f3, rd, rs1, rs2);
      end else begin
        word = enc_r(rv_pkg::f7_base, f3, rd, rs1, rs2);
      end
    end else if (kind < 65) begin
      if (f3 == rv_pkg::f3_sll) imm[11:6] = 6'b000000;
      if (f3 == rv_pkg::f3_srl_sra) imm[11:6] = ($urandom % 2 == 1) ? 6'b010000 : 6'b000000;
      word = enc_i(f3, rd, rs1, imm);
    end else if (kind < 78) begin
      word = {20'($urandom), rd, rv_pkg::opc_lui};
    end else if (kind < 86) begin
      word = $urandom; // Mostly unknown opcodes.
    end else if (kind < 93) begin
      word = enc_r(7'($urandom), f3, rd, rs1, rs2); // Odd funct7.
    end else begin
      word = enc_i(rv_pkg::f3_srl_sra, rd, rs1, {6'($urandom), imm[5:0]});
    end
    last_rd = word[11:7];
    return word;
  endfunction

  // One cycle. Check the last result, then drive the next inputs.
  task automatic step(input logic valid, input logic [31:0] word, input logic [4:0] dbg);
    logic        legal;
    logic [63:0] res;
    @(negedge clk);
    check("retire_valid", 64'(retire_valid), 64'(exp_retire));
    check("illegal", 64'(illegal), 64'(exp_illegal));
    if (exp_retire) begin
      check("retire_rd", 64'(retire_rd), 64'(exp_rd));
      check("retire_data", retire_data, exp_data);
    end
    check("dbg_data", dbg_data, model_regs[dbg_addr]);
    instr_valid = valid;
    instr       = word;
    dbg_addr    = dbg;
    legal       = predict(word, res);
    exp_retire  = valid && legal;
    exp_illegal = valid && !legal;
    exp_rd      = word[11:7];
    exp_data    = res; // x0 writes still retire the result.
    if (exp_retire && word[11:7] != 5'd0) model_regs[word[11:7]] = res;
  endtask

  initial begin
    logic [31:0] word;
    void'($urandom(seed));
    rst         = 1'b1;
    instr_valid = 1'b0;
    instr       = '0;
    dbg_addr    = '0;
    exp_retire  = 1'b0;
    exp_illegal = 1'b0;
    exp_rd      = '0;
    exp_data    = '0;
    last_rd     = '0;
    for (int i = 0; i < rv_pkg::reg_num; i++) model_regs[i] = rv_pkg::reg_init;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // Every register starts at the reset value.
    for (int i = 0; i < rv_pkg::reg_num; i++) step(1'b0, '0, 5'(i));

    // Directed cases. x0 writes, a dependent chain, SRAI against SRLI.
    step(1'b1, enc_i(rv_pkg::f3_add_sub, 5'd0, 5'd0, 12'h123), 5'd0);
    step(1'b1, enc_r(rv_pkg::f7_base, rv_pkg::f3_add_sub, 5'd5, 5'd0, 5'd0), 5'd5);
    step(1'b1, enc_i(rv_pkg::f3_add_sub, 5'd1, 5'd0, 12'h808), 5'd1); // Negative.
    step(1'b1, enc_i(rv_pkg::f3_sll, 5'd1, 5'd1, 12'h03c), 5'd1);     // Shift by 60.
    step(1'b1, enc_i(rv_pkg::f3_srl_sra, 5'd2, 5'd1, 12'h424), 5'd2); // SRAI by 36.
    step(1'b1, enc_i(rv_pkg::f3_srl_sra, 5'd3, 5'd1, 12'h024), 5'd3); // SRLI by 36.
    step(1'b1, enc_r(rv_pkg::f7_base, rv_pkg::f3_slt, 5'd4, 5'd2, 5'd3), 5'd4);
    step(1'b1, enc_r(rv_pkg::f7_base, rv_pkg::f3_sltu, 5'd4, 5'd2, 5'd3), 5'd4);
    step(1'b1, {20'hfffff, 5'd6, rv_pkg::opc_lui}, 5'd6);             // Upper sign bit.
    step(1'b1, 32'hffff_ffff, 5'd6);                                  // Illegal.

    for (int n = 0; n < n_instr; n++) begin
      word = random_instr();
      step(($urandom % 10) != 0, word, 5'($urandom));
    end

    // Final sweep against the model.
    for (int i = 0; i < rv_pkg::reg_num; i++) step(1'b0, '0, 5'(i));
    step(1'b0, '0, 5'd0);

    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: rv_int_core.f
logic/rv_pkg.sv
logic/rv_decode.sv
logic/rv_reg_file.sv
logic/rv_alu.sv
logic/rv_int_core.sv
test/rv_int_core_assert.sv
test/rv_int_core_tb.sv

// File: build.sh
#!/usr/bin/env bash
# Compile the testbench with Verilator and run it.
# The exit status is the simulation's own.
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f rv_int_core.f \
  --top-module rv_int_core_tb \
  -Mdir obj_dir \
  && ./obj_dir/Vrv_int_core_tb \
  || { echo "simulation did not pass"; exit 1; }
